/* list.f */
verilog/spi_pkg.sv
verilog/spi_bit_if.sv
verilog/spi_cmd_fsm.sv
verilog/spi_sclk_timer.sv
verilog/spi_shift_reg.sv
verilog/spi_master.sv
testbench/spi_slave_model.sv
testbench/tb_spi_master.sv

/* run_sim.sh */
#!/bin/sh
# Compile the SPI master and its testbench with Verilator, then run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_spi_master -Mdir obj_dir -f list.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_spi_master
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi
exit 0

/* testbench/spi_slave_model.sv */
module spi_slave_model (
  input  logic        cs,
  input  logic        sclk,
  input  logic        mosi,
  output logic        miso,
  output logic [11:0] frame_word,
  output int          frame_bits,
  output int          frame_count
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  regs [0:7];
  logic [11:0] shift_in;
  int          bit_cnt;
  logic        read_frame;
  logic [2:0]  req_addr;

  initial
  begin
    regs        = '{default: '0};
    shift_in    = '0;
    bit_cnt     = 0;
    read_frame  = 1'b0;
    req_addr    = '0;
    miso        = 1'b0;
    frame_word  = '0;
    frame_bits  = 0;
    frame_count = 0;
  end

  // MOSI is taken on the rising edge, cs high closes the frame.
  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if (bit_cnt > 0)
      begin
        frame_word  <= shift_in;
        frame_bits  <= bit_cnt;
        frame_count <= frame_count + 1;
        if (shift_in[11] && (bit_cnt == 12))
          regs[shift_in[10:8]] <= shift_in[7:0]; // Write frame stores its byte.
      end
      bit_cnt  <= 0;
      shift_in <= '0;
    end
    else
    begin
      shift_in <= {shift_in[10:0], mosi};
      bit_cnt  <= bit_cnt + 1;
      if (bit_cnt == 3) // Flag and address are complete with this bit.
      begin
        read_frame <= !shift_in[2];
        req_addr   <= {shift_in[1:0], mosi};
      end
    end
  end

  // Read data leaves MSB first, starting at the fourth falling edge.
  always @(negedge sclk)
  begin
    if (!cs && read_frame && (bit_cnt >= 4) && (bit_cnt < 12))
      miso <= regs[req_addr][3'(11 - bit_cnt)];
  end

endmodule

/* testbench/spi_trace.txt */
// Columns are the command, the gap and the expected read byte, all in hex.
// The gap counts clk cycles from acceptance to the next cmd_vld.
// Write lines carry 00 in the last column.
300 00 00
8A5 00 00
95C 3C 00
000 00 A5
1FF 00 5C
F81 05 00
700 40 81
A3C 00 00
8FF 00 00
000 0A FF
200 00 3C
E00 1E 00
600 00 00
D96 32 00
500 00 96
455 00 00

/* testbench/tb_spi_master.sv */
module tb_spi_master;

  timeunit 1ns;
  timeprecision 100ps;

  import spi_pkg::*;

  localparam int CS_LOW_CLKS = 2 * SCLK_HALF * FRAME_BITS + 1; // cs drops one clk in.
  localparam int WAIT_LIMIT  = 200;

  logic                 clk;
  logic                 rst_n;
  spi_cmd_t             cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 sclk;
  logic                 cs;
  logic                 mosi;
  logic                 miso;
  logic                 read_vld;
  read_data_t           read_data;
  logic [CMD_WIDTH-1:0] slave_word;
  int                   slave_bits;
  int                   slave_frames;

  spi_cmd_t   trace_cmd[$];
  int         trace_gap[$];
  read_data_t trace_exp[$];

  spi_master i_spi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model i_spi_slave_model (
    .cs          (cs),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .frame_word  (slave_word),
    .frame_bits  (slave_bits),
    .frame_count (slave_frames)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic report_error(input string msg);
    fail_run($sformatf("ERR at %0t ns: %s", $time, msg));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_read(input read_data_t got, input read_data_t exp);
    if (got !== exp)
      report_error($sformatf("read_data is %h, expected %h", got, exp));
  endtask

  // A read frame only defines the flag and the address on MOSI.
  task automatic check_cmd(input spi_cmd_t got, input spi_cmd_t exp);
    if (exp.wr.rw && (got !== exp))
      report_error($sformatf("slave saw write %h, expected %h", got, exp));
    else if (!exp.wr.rw && ((got.rd.rw !== 1'b0) || (got.rd.addr !== exp.rd.addr)))
      report_error($sformatf("slave saw %h for read of address %0d", got, exp.rd.addr));
  endtask

  task automatic load_trace();
    int          fd;
    int          got;
    string       line;
    logic [31:0] cmd_word;
    logic [31:0] gap;
    logic [31:0] exp_byte;
    fd = $fopen("testbench/spi_trace.txt", "r");
    if (fd == 0)
      fail_run("Could not open testbench/spi_trace.txt.");
    while (!$feof(fd))
    begin
      got = $fgets(line, fd);
      if ((got > 0) && ($sscanf(line, "%h %h %h", cmd_word, gap, exp_byte) == 3))
      begin
        trace_cmd.push_back(spi_cmd_t'(cmd_word[CMD_WIDTH-1:0]));
        trace_gap.push_back(int'(gap));
        trace_exp.push_back(read_data_t'(exp_byte[READ_WIDTH-1:0]));
      end
    end
    $fclose(fd);
    if (trace_cmd.size() == 0)
      fail_run("The trace file holds no commands.");
  endtask

  // Gap counts clk from acceptance, so a short one leaves cmd_vld held into the next frame.
  task automatic send_trace();
    int i;
    int gap;
    int waited;
    for (i = 0; i < trace_cmd.size(); i++)
    begin
      cmd_in  = trace_cmd[i];
      cmd_vld = 1'b1;
      waited  = 0;
      while (!cmd_rdy)
      begin
        @(posedge clk);
        #2;
        waited++;
        if (waited > WAIT_LIMIT)
          fail_run("Timed out waiting for cmd_rdy.");
      end
      @(posedge clk); // Handshake.
      #2;
      gap = trace_gap[i] + int'($urandom_range(7, 0));
      if ((gap > 0) || (i == trace_cmd.size() - 1))
        cmd_vld = 1'b0;
      repeat (gap)
      begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic watch_frames();
    int         i;
    int         waited;
    int         low_clks;
    read_data_t last_read;
    last_read = '0;
    for (i = 0; i < trace_cmd.size(); i++)
    begin
      waited = 0;
      @(negedge clk);
      while (cs)
      begin
        waited++;
        if (waited > WAIT_LIMIT)
          fail_run("Timed out waiting for cs to go low.");
        @(negedge clk);
      end
      low_clks = 0;
      while (!cs)
      begin
        check_bit(cmd_rdy, 1'b0, "cmd_rdy during frame");
        check_bit(read_vld, 1'b0, "read_vld during frame");
        low_clks++;
        if (low_clks > WAIT_LIMIT)
          fail_run("Timed out waiting for cs to go high.");
        @(negedge clk);
      end
      check_count(low_clks, CS_LOW_CLKS, "clk cycles with cs low");
      check_count(slave_frames, i + 1, "frames seen by slave");
      check_count(slave_bits, FRAME_BITS, "SCLK rising edges in frame");
      check_cmd(spi_cmd_t'(slave_word), trace_cmd[i]);
      check_bit(cmd_rdy, 1'b1, "cmd_rdy after frame");
      if (trace_cmd[i].wr.rw)
      begin
        check_bit(read_vld, 1'b0, "read_vld after write");
        check_read(read_data, last_read); // Held from the last read.
      end
      else
      begin
        check_bit(read_vld, 1'b1, "read_vld after read");
        check_read(read_data, trace_exp[i]);
        last_read = trace_exp[i];
      end
      @(negedge clk);
      check_bit(read_vld, 1'b0, "read_vld one clk later");
    end
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    void'($urandom(32'h3921_20c8));
    load_trace();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(cs, 1'b1, "cs after reset");
    check_bit(sclk, 1'b0, "sclk after reset");
    check_bit(mosi, 1'b0, "mosi after reset");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_bit(read_vld, 1'b0, "read_vld after reset");
    check_read(read_data, '0);
    @(posedge clk);
    #2;
    fork
      send_trace();
      watch_frames();
    join
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* verilog/spi_bit_if.sv */
interface spi_bit_if;

  logic frame_start; // One clk pulse at command acceptance.
  logic shift_en;    // SCLK falls on the next edge.
  logic sample_en;   // SCLK rises on the next edge.
  logic frame_done;  // Registered, after the last falling edge.

  modport fsm (
    output frame_start,
    input  frame_done
  );

  modport timer (
    input  frame_start,
    output shift_en,
    output sample_en,
    output frame_done
  );

  modport shifter (
    input  frame_start,
    input  shift_en,
    input  sample_en
  );

endinterface

/* verilog/spi_cmd_fsm.sv */
module spi_cmd_fsm (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cmd_vld,
  input  logic   cmd_rw,
  output logic   cmd_rdy,
  output logic   cs,
  output logic   read_vld,
  spi_bit_if.fsm bits
);

  import spi_pkg::*;

  spi_state_t state;
  spi_state_t state_nxt;
  logic       accept;
  logic       read_frame;

  assign cmd_rdy = (state == IDLE);
  assign accept  = cmd_vld && cmd_rdy;

  // Shifter and timer start on the handshake itself, while cmd_in is still valid.
  assign bits.frame_start = accept;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (accept)
          state_nxt = LOAD;
      end
      LOAD:
      begin
        state_nxt = SHIFT;
      end
      SHIFT:
      begin
        if (bits.frame_done)
          state_nxt = FINISH;
      end
      FINISH:
      begin
        state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Bit 11 low means read.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_frame <= 1'b0;
    else if (accept)
      read_frame <= !cmd_rw;
  end

  // Chip select follows the state one clk late, so it stays clean of decode glitches.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs <= 1'b1;
    end
    else
    begin
      cs <= !((state == LOAD) || (state == SHIFT));
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_vld <= 1'b0;
    else
      read_vld <= (state == FINISH) && read_frame; // Lines up with cs going high.
  end

endmodule

/* verilog/spi_master.sv */
module spi_master (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                sclk,
  output logic                cs,
  output logic                mosi,
  input  logic                miso,
  output logic                read_vld,
  output spi_pkg::read_data_t read_data
);

  spi_bit_if bits ();

  // Command handshake, chip select and result strobe.
  spi_cmd_fsm i_spi_cmd_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_rw   (cmd_in.wr.rw),
    .cmd_rdy  (cmd_rdy),
    .cs       (cs),
    .read_vld (read_vld),
    .bits     (bits.fsm)
  );

  spi_sclk_timer i_spi_sclk_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .sclk  (sclk),
    .bits  (bits.timer)
  );

  spi_shift_reg i_spi_shift_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .miso      (miso),
    .mosi      (mosi),
    .read_data (read_data),
    .bits      (bits.shifter)
  );

endmodule

/* verilog/spi_pkg.sv */
package spi_pkg;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int ADDR_WIDTH = 3;
  localparam int FRAME_BITS = 12; // SCLK periods per frame, same for reads and writes.
  localparam int SCLK_HALF  = 2;  // System clocks per SCLK half period.

  localparam int DIV_WIDTH = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
  localparam int CNT_WIDTH = $clog2(FRAME_BITS + 1);

  // Write command: flag, register address and the byte to store.
  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [READ_WIDTH-1:0] wdata;
  } spi_wr_cmd_t;

  // Read command: the low byte carries nothing.
  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [READ_WIDTH-1:0] pad;
  } spi_rd_cmd_t;

  // Bit 11 decides which view applies.
  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_t;

  typedef logic [READ_WIDTH-1:0] read_data_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    SHIFT  = 2'd2,
    FINISH = 2'd3
  } spi_state_t;

endpackage

/* verilog/spi_sclk_timer.sv */
module spi_sclk_timer (
  input  logic     clk,
  input  logic     rst_n,
  output logic     sclk,
  spi_bit_if.timer bits
);

  import spi_pkg::*;

  logic                 active;
  logic [DIV_WIDTH-1:0] div_cnt;
  logic [CNT_WIDTH-1:0] bit_cnt;
  logic                 tick;
  logic                 last_fall;

  // One tick per half period, SCLK toggles on the edge that follows it.
  assign tick           = active && (div_cnt == DIV_WIDTH'(SCLK_HALF - 1));
  assign bits.sample_en = tick && !sclk;
  assign bits.shift_en  = tick && sclk;

  // Falling edge after the twelfth rising edge.
  assign last_fall = bits.shift_en && (bit_cnt == CNT_WIDTH'(FRAME_BITS));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      div_cnt <= '0;
    end
    else if (bits.frame_start)
    begin
      active  <= 1'b1;
      div_cnt <= '0;
    end
    else if (active)
    begin
      if (tick)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
      if (last_fall)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sclk <= 1'b0; // Mode 0 idles low.
    else if (bits.frame_start)
      sclk <= 1'b0;
    else if (tick)
      sclk <= !sclk;
  end

  // Counts rising edges.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (bits.frame_start)
      bit_cnt <= '0;
    else if (bits.sample_en)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bits.frame_done <= 1'b0;
    else
      bits.frame_done <= last_fall;
  end

endmodule

/* verilog/spi_shift_reg.sv */
module spi_shift_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic                miso,
  output logic                mosi,
  output spi_pkg::read_data_t read_data,
  spi_bit_if.shifter          bits
);

  import spi_pkg::*;

  logic [CMD_WIDTH-1:0]  tx_load;
  logic [CMD_WIDTH-1:0]  tx_shift;
  logic [READ_WIDTH-1:0] rx_shift;
  logic [CNT_WIDTH-1:0]  sample_cnt;
  logic                  read_frame;
  logic                  last_sample;

  // A write sends its data byte, a read keeps MOSI low while the slave answers.
  always_comb
  begin
    if (cmd_in.wr.rw)
      tx_load = {cmd_in.wr.rw, cmd_in.wr.addr, cmd_in.wr.wdata};
    else
      tx_load = {cmd_in.rd.rw, cmd_in.rd.addr, {READ_WIDTH{1'b0}}};
  end

  assign mosi        = tx_shift[CMD_WIDTH-1]; // MSB first.
  assign last_sample = bits.sample_en && (sample_cnt == CNT_WIDTH'(FRAME_BITS - 1));

  // Zeros fill from the bottom, so MOSI is back at 0 once the frame ends.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_shift <= '0;
    else if (bits.frame_start)
      tx_shift <= tx_load;
    else if (bits.shift_en)
      tx_shift <= {tx_shift[CMD_WIDTH-2:0], 1'b0};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_frame <= 1'b0;
      sample_cnt <= '0;
    end
    else if (bits.frame_start)
    begin
      read_frame <= !cmd_in.rd.rw;
      sample_cnt <= '0;
    end
    else if (bits.sample_en)
    begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // Samples taken during the address phase fall out of the top.
  always_ff @(posedge clk)
  begin
    if (bits.sample_en)
      rx_shift <= {rx_shift[READ_WIDTH-2:0], miso};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (last_sample && read_frame)
      read_data <= {rx_shift[READ_WIDTH-2:0], miso}; // Held until the next read.
  end

endmodule
